/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;
    localparam int TAG_W = 6;
    localparam int NUM_PREGS = 64;       // tag 0 reads as constant zero
    localparam int RS_DEPTH = 4;
    localparam int NUM_UNITS = 3;
    localparam int RF_RD_PORTS = 4;
    localparam int RS_IDX_W = $clog2(RS_DEPTH);
    localparam int STEP_W = $clog2(XLEN + 1);
    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [XLEN-1:0] data_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [NUM_UNITS-1:0] unit_flags_t;  // indexed by unit_e

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_fn_e;

    // mul and div codes overlap
    typedef logic [1:0] md_fn_e;
    localparam md_fn_e MD_MUL = 2'd0;
    localparam md_fn_e MD_MULH = 2'd1;
    localparam md_fn_e MD_MULHU = 2'd2;
    localparam md_fn_e MD_DIV = 2'd0;
    localparam md_fn_e MD_DIVU = 2'd1;
    localparam md_fn_e MD_REM = 2'd2;
    localparam md_fn_e MD_REMU = 2'd3;

    typedef struct packed {
        unit_e      unit;
        logic [3:0] fn;
        tag_t       src1;
        tag_t       src2;
        tag_t       dest;
        logic       use_imm;
        data_t      imm;
    } dispatch_t;

    typedef struct packed {
        alu_fn_e fn;
        logic    use_imm;
        data_t   imm;
        tag_t    dest;
    } alu_payload_t;

    typedef struct packed {
        md_fn_e fn;
        tag_t   dest;
    } md_payload_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } wb_t;

    // one source operand as held in a station entry
    typedef struct packed {
        tag_t  tag;
        data_t value;
        logic  ready;
    } operand_t;

endpackage

`default_nettype wire

/* src/phys_regfile.sv */
`default_nettype none

module phys_regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            alloc_valid,
    input  exec_pkg::tag_t  alloc_tag,
    input  exec_pkg::tag_t  rd_tag [exec_pkg::RF_RD_PORTS],
    output exec_pkg::data_t rd_data [exec_pkg::RF_RD_PORTS],
    output logic            rd_ready [exec_pkg::RF_RD_PORTS],
    input  exec_pkg::wb_t   wb [exec_pkg::NUM_UNITS]
);
    import exec_pkg::*;

    data_t regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= '1;
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alloc_valid && alloc_tag != '0) begin
                ready[alloc_tag] <= 1'b0;   // pending until broadcast
            end
            // buses never share a tag
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (wb[u].valid && wb[u].tag != '0) begin
                    regs[wb[u].tag] <= wb[u].data;
                    ready[wb[u].tag] <= 1'b1;
                end
            end
        end
    end

    // stored state only, stations catch same-cycle broadcasts themselves
    always_comb begin
        for (int p = 0; p < RF_RD_PORTS; p++) begin
            rd_data[p] = regs[rd_tag[p]];
            rd_ready[p] = ready[rd_tag[p]];
        end
    end

endmodule

`default_nettype wire

/* src/reservation_station.sv */
`default_nettype none

module reservation_station #(
    parameter type payload_t = logic
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            alloc,
    input  payload_t        alloc_payload,
    input  exec_pkg::tag_t  src1_tag,
    input  exec_pkg::tag_t  src2_tag,
    input  exec_pkg::data_t src1_data,
    input  exec_pkg::data_t src2_data,
    input  logic            src1_ready,
    input  logic            src2_ready,
    input  exec_pkg::wb_t   wb [exec_pkg::NUM_UNITS],
    output logic            full,
    input  logic            unit_busy,
    output logic            issue_valid,
    output payload_t        issue_payload,
    output exec_pkg::data_t op_a,
    output exec_pkg::data_t op_b
);
    import exec_pkg::*;

    logic [RS_DEPTH-1:0] valid;
    logic [RS_IDX_W-1:0] age [RS_DEPTH];  // count of younger live entries
    payload_t payload [RS_DEPTH];
    operand_t opnd1 [RS_DEPTH];
    operand_t opnd2 [RS_DEPTH];

    logic [RS_IDX_W-1:0] sel;
    logic [RS_IDX_W-1:0] free_slot;
    logic found;
    logic take;

    function automatic operand_t wake(operand_t op, wb_t bus [NUM_UNITS]);
        operand_t res;
        res = op;
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (!res.ready && bus[u].valid && bus[u].tag == res.tag) begin
                res.value = bus[u].data;
                res.ready = 1'b1;
            end
        end
        return res;
    endfunction

    // oldest ready entry has the largest age
    always_comb begin
        found = 1'b0;
        sel = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid[i] && opnd1[i].ready && opnd2[i].ready &&
                (!found || age[i] > age[sel])) begin
                found = 1'b1;
                sel = RS_IDX_W'(i);
            end
        end
    end

    always_comb begin
        free_slot = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_slot = RS_IDX_W'(i);
            end
        end
    end

    assign full = &valid;
    assign take = alloc && !full;
    assign issue_valid = found && !unit_busy;
    assign issue_payload = payload[sel];
    assign op_a = opnd1[sel].value;
    assign op_b = opnd2[sel].value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (take && RS_IDX_W'(i) == free_slot) begin
                    valid[i] <= 1'b1;
                    age[i] <= '0;
                end else if (issue_valid && RS_IDX_W'(i) == sel) begin
                    valid[i] <= 1'b0;
                end else if (valid[i]) begin
                    // older than the issuing entry loses one younger peer
                    age[i] <= age[i] + RS_IDX_W'(take)
                              - RS_IDX_W'(issue_valid && age[i] > age[sel]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (take && RS_IDX_W'(i) == free_slot) begin
                payload[i] <= alloc_payload;
                opnd1[i] <= wake('{tag: src1_tag, value: src1_data, ready: src1_ready}, wb);
                opnd2[i] <= wake('{tag: src2_tag, value: src2_data, ready: src2_ready}, wb);
            end else begin
                opnd1[i] <= wake(opnd1[i], wb);
                opnd2[i] <= wake(opnd2[i], wb);
            end
        end
    end

endmodule

`default_nettype wire

/* src/int_alu.sv */
`default_nettype none

module int_alu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  exec_pkg::alu_payload_t payload,
    input  exec_pkg::data_t        op_a,
    input  exec_pkg::data_t        op_b,
    output exec_pkg::wb_t          wb
);
    import exec_pkg::*;

    data_t b;
    data_t result;
    logic [SHAMT_W-1:0] shamt;
    logic valid_q;
    tag_t tag_q;
    data_t data_q;

    assign b = payload.use_imm ? payload.imm : op_b;
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (payload.fn)
            ALU_ADD:  result = op_a + b;
            ALU_SUB:  result = op_a - b;
            ALU_AND:  result = op_a & b;
            ALU_OR:   result = op_a | b;
            ALU_XOR:  result = op_a ^ b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = data_t'($signed(op_a) >>> shamt);
            ALU_SLT:  result = data_t'($signed(op_a) < $signed(b));
            ALU_SLTU: result = data_t'(op_a < b);
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            tag_q <= payload.dest;
            data_q <= result;
        end
    end

    assign wb = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

/* src/seq_multiplier.sv */
`default_nettype none

module seq_multiplier (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  exec_pkg::md_payload_t payload,
    input  exec_pkg::data_t       op_a,
    input  exec_pkg::data_t       op_b,
    output logic                  busy,
    output exec_pkg::wb_t         wb
);
    import exec_pkg::*;

    logic [STEP_W-1:0] step;
    logic last;
    logic is_signed;
    data_t mcand;
    logic [2*XLEN-1:0] prod;     // upper half accumulates, lower half holds multiplier
    logic [XLEN:0] partial;
    logic [2*XLEN-1:0] product;
    logic negate;
    logic high;
    logic valid_q;
    tag_t tag_q;
    data_t data_q;

    assign is_signed = payload.fn == MD_MULH;
    assign last = busy && step == STEP_W'(XLEN);
    assign partial = {1'b0, prod[2*XLEN-1:XLEN]} + (prod[0] ? {1'b0, mcand} : '0);
    assign product = negate ? -prod : prod;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= last;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= (is_signed && op_a[XLEN-1]) ? -op_a : op_a;
            prod <= {{XLEN{1'b0}}, (is_signed && op_b[XLEN-1]) ? -op_b : op_b};
            negate <= is_signed && (op_a[XLEN-1] ^ op_b[XLEN-1]);
            high <= payload.fn == MD_MULH || payload.fn == MD_MULHU;
            tag_q <= payload.dest;
        end else if (busy && !last) begin
            prod <= {partial, prod[XLEN-1:1]};
        end
        if (last) begin
            data_q <= high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
        end
    end

    assign wb = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

/* src/seq_divider.sv */
`default_nettype none

module seq_divider (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  exec_pkg::md_payload_t payload,
    input  exec_pkg::data_t       op_a,
    input  exec_pkg::data_t       op_b,
    output logic                  busy,
    output exec_pkg::wb_t         wb
);
    import exec_pkg::*;

    logic [STEP_W-1:0] step;
    logic last;
    logic is_signed;
    data_t dvsr;
    data_t quo;          // dividend shifts out as quotient bits shift in
    data_t rem;
    logic [XLEN:0] shifted;
    logic [XLEN:0] diff;
    logic q_neg;
    logic r_neg;
    logic want_rem;
    data_t quotient;
    data_t remainder;
    logic valid_q;
    tag_t tag_q;
    data_t data_q;

    assign is_signed = payload.fn == MD_DIV || payload.fn == MD_REM;
    assign last = busy && step == STEP_W'(XLEN);
    assign shifted = {rem, quo[XLEN-1]};
    assign diff = shifted - {1'b0, dvsr};
    assign quotient = q_neg ? -quo : quo;
    assign remainder = r_neg ? -rem : rem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= last;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo <= (is_signed && op_a[XLEN-1]) ? -op_a : op_a;
            dvsr <= (is_signed && op_b[XLEN-1]) ? -op_b : op_b;
            rem <= '0;
            // zero divisor leaves all ones, so no sign flip then
            q_neg <= is_signed && (op_a[XLEN-1] ^ op_b[XLEN-1]) && op_b != '0;
            r_neg <= is_signed && op_a[XLEN-1];
            want_rem <= !(payload.fn == MD_DIV || payload.fn == MD_DIVU);
            tag_q <= payload.dest;
        end else if (busy && !last) begin
            if (!diff[XLEN]) begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= shifted[XLEN-1:0];   // restore
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
        if (last) begin
            data_q <= want_rem ? remainder : quotient;
        end
    end

    assign wb = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

/* src/exec_core.sv */
`default_nettype none

module exec_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dispatch_valid,
    input  exec_pkg::dispatch_t   dispatch,
    output exec_pkg::unit_flags_t stall,
    output exec_pkg::wb_t         alu_wb,
    output exec_pkg::wb_t         mul_wb,
    output exec_pkg::wb_t         div_wb
);
    import exec_pkg::*;

    unit_flags_t alloc;
    alu_payload_t alu_payload;
    md_payload_t md_payload;
    tag_t alu_src2;
    tag_t rd_tag [RF_RD_PORTS];
    data_t rd_data [RF_RD_PORTS];
    logic rd_ready [RF_RD_PORTS];
    wb_t wb_bus [NUM_UNITS];

    logic alu_issue_valid;
    alu_payload_t alu_issue;
    data_t alu_op_a;
    data_t alu_op_b;
    logic mul_issue_valid;
    logic div_issue_valid;
    md_payload_t mul_issue;
    md_payload_t div_issue;
    data_t mul_op_a;
    data_t mul_op_b;
    data_t div_op_a;
    data_t div_op_b;
    logic mul_busy;
    logic div_busy;

    assign alloc[UNIT_ALU] = dispatch_valid && dispatch.unit == UNIT_ALU;
    assign alloc[UNIT_MUL] = dispatch_valid && dispatch.unit == UNIT_MUL;
    assign alloc[UNIT_DIV] = dispatch_valid && dispatch.unit == UNIT_DIV;

    assign alu_src2 = dispatch.use_imm ? '0 : dispatch.src2;  // immediates read tag 0
    assign alu_payload = '{fn: alu_fn_e'(dispatch.fn), use_imm: dispatch.use_imm,
                           imm: dispatch.imm, dest: dispatch.dest};
    assign md_payload = '{fn: dispatch.fn[1:0], dest: dispatch.dest};

    // ports 0/1 for alu, 2/3 shared by mul and div
    assign rd_tag[0] = dispatch.src1;
    assign rd_tag[1] = alu_src2;
    assign rd_tag[2] = dispatch.src1;
    assign rd_tag[3] = dispatch.src2;

    assign wb_bus[UNIT_ALU] = alu_wb;
    assign wb_bus[UNIT_MUL] = mul_wb;
    assign wb_bus[UNIT_DIV] = div_wb;

    phys_regfile phys_regfile_inst (
        .clk(clk),
        .rst_n(rst_n),
        .alloc_valid(|(alloc & ~stall)),
        .alloc_tag(dispatch.dest),
        .rd_tag(rd_tag),
        .rd_data(rd_data),
        .rd_ready(rd_ready),
        .wb(wb_bus)
    );

    reservation_station #(
        .payload_t(alu_payload_t)
    ) alu_rs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .alloc(alloc[UNIT_ALU]),
        .alloc_payload(alu_payload),
        .src1_tag(dispatch.src1),
        .src2_tag(alu_src2),
        .src1_data(rd_data[0]),
        .src2_data(rd_data[1]),
        .src1_ready(rd_ready[0]),
        .src2_ready(rd_ready[1]),
        .wb(wb_bus),
        .full(stall[UNIT_ALU]),
        .unit_busy(1'b0),
        .issue_valid(alu_issue_valid),
        .issue_payload(alu_issue),
        .op_a(alu_op_a),
        .op_b(alu_op_b)
    );

    reservation_station #(
        .payload_t(md_payload_t)
    ) mul_rs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .alloc(alloc[UNIT_MUL]),
        .alloc_payload(md_payload),
        .src1_tag(dispatch.src1),
        .src2_tag(dispatch.src2),
        .src1_data(rd_data[2]),
        .src2_data(rd_data[3]),
        .src1_ready(rd_ready[2]),
        .src2_ready(rd_ready[3]),
        .wb(wb_bus),
        .full(stall[UNIT_MUL]),
        .unit_busy(mul_busy),
        .issue_valid(mul_issue_valid),
        .issue_payload(mul_issue),
        .op_a(mul_op_a),
        .op_b(mul_op_b)
    );

    reservation_station #(
        .payload_t(md_payload_t)
    ) div_rs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .alloc(alloc[UNIT_DIV]),
        .alloc_payload(md_payload),
        .src1_tag(dispatch.src1),
        .src2_tag(dispatch.src2),
        .src1_data(rd_data[2]),
        .src2_data(rd_data[3]),
        .src1_ready(rd_ready[2]),
        .src2_ready(rd_ready[3]),
        .wb(wb_bus),
        .full(stall[UNIT_DIV]),
        .unit_busy(div_busy),
        .issue_valid(div_issue_valid),
        .issue_payload(div_issue),
        .op_a(div_op_a),
        .op_b(div_op_b)
    );

    int_alu int_alu_inst (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(alu_issue_valid),
        .payload(alu_issue),
        .op_a(alu_op_a),
        .op_b(alu_op_b),
        .wb(alu_wb)
    );

    seq_multiplier seq_multiplier_inst (
        .clk(clk),
        .rst_n(rst_n),
        .start(mul_issue_valid),
        .payload(mul_issue),
        .op_a(mul_op_a),
        .op_b(mul_op_b),
        .busy(mul_busy),
        .wb(mul_wb)
    );

    seq_divider seq_divider_inst (
        .clk(clk),
        .rst_n(rst_n),
        .start(div_issue_valid),
        .payload(div_issue),
        .op_a(div_op_a),
        .op_b(div_op_b),
        .busy(div_busy),
        .wb(div_wb)
    );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // low across the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/exec_core_sva.sv */
`default_nettype none

module exec_core_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  dispatch_valid,
    input exec_pkg::unit_flags_t stall,
    input exec_pkg::wb_t         alu_wb,
    input exec_pkg::wb_t         mul_wb,
    input exec_pkg::wb_t         div_wb
);
    timeunit 1ns;
    timeprecision 1ps;

    logic seen_dispatch;
    int unsigned fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_dispatch <= 1'b0;
        end else if (dispatch_valid) begin
            seen_dispatch <= 1'b1;
        end
    end

    quiet_before_dispatch: assert property (
        @(posedge clk) disable iff (!rst_n)
        !seen_dispatch |-> !(alu_wb.valid || mul_wb.valid || div_wb.valid) && stall == '0
    ) else begin
        fail_count++;
        $error("broadcast or stall seen before the first dispatch");
    end

    stall_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> stall == '0
    ) else begin
        fail_count++;
        $error("stall set when reset was released");
    end

    // one op in flight, so pulses are isolated
    mul_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) mul_wb.valid |=> !mul_wb.valid
    ) else begin
        fail_count++;
        $error("mul_wb valid in two consecutive cycles");
    end

    div_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) div_wb.valid |=> !div_wb.valid
    ) else begin
        fail_count++;
        $error("div_wb valid in two consecutive cycles");
    end

    distinct_tags: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(alu_wb.valid && mul_wb.valid && alu_wb.tag == mul_wb.tag) &&
        !(alu_wb.valid && div_wb.valid && alu_wb.tag == div_wb.tag) &&
        !(mul_wb.valid && div_wb.valid && mul_wb.tag == div_wb.tag)
    ) else begin
        fail_count++;
        $error("two result buses carry the same tag");
    end

endmodule

bind exec_core exec_core_sva exec_core_sva_inst (
    .clk(clk),
    .rst_n(rst_n),
    .dispatch_valid(dispatch_valid),
    .stall(stall),
    .alu_wb(alu_wb),
    .mul_wb(mul_wb),
    .div_wb(div_wb)
);

`default_nettype wire

/* verif/exec_core_tb.sv */
`default_nettype none

module exec_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    logic clk;
    logic rst_n;
    logic dispatch_valid;
    dispatch_t dispatch;
    unit_flags_t stall;
    wb_t alu_wb;
    wb_t mul_wb;
    wb_t div_wb;

    data_t exp_val [NUM_PREGS];     // shadow value per tag
    logic [NUM_PREGS-1:0] pending;  // dispatched, no broadcast yet
    logic [31:0] rng;
    tag_t next_tag;
    int dispatched;

    tb_clock tb_clock_inst (
        .clk(clk),
        .rst_n(rst_n)
    );

    exec_core exec_core_inst (
        .clk(clk),
        .rst_n(rst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch(dispatch),
        .stall(stall),
        .alu_wb(alu_wb),
        .mul_wb(mul_wb),
        .div_wb(div_wb)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic data_t next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic tag_on_bus(tag_t t);
        return (alu_wb.valid && alu_wb.tag == t) || (mul_wb.valid && mul_wb.tag == t) ||
               (div_wb.valid && div_wb.tag == t);
    endfunction

    function automatic data_t alu_model(alu_fn_e fn, data_t a, data_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (fn)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $signed(a) >>> sh;
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic data_t mul_model(md_fn_e fn, data_t a, data_t b);
        logic signed [63:0] sp;
        logic [63:0] up;
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'b0, a} * {32'b0, b};
        if (fn == MD_MULH) begin
            return sp[63:32];
        end
        return (fn == MD_MULHU) ? up[63:32] : up[31:0];
    endfunction

    function automatic data_t div_model(md_fn_e fn, data_t a, data_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (b == '0) begin
            return (fn == MD_DIV || fn == MD_DIVU) ? '1 : a;
        end
        if (fn == MD_DIV || fn == MD_REM) begin
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                return (fn == MD_DIV) ? a : '0;  // signed overflow
            end
            return (fn == MD_DIV) ? data_t'(sa / sb) : data_t'(sa % sb);
        end
        return (fn == MD_DIVU) ? a / b : a % b;
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic send_op(input unit_e unit, input logic [3:0] fn, input tag_t src1,
                           input tag_t src2, input logic use_imm, input data_t imm,
                           output tag_t dest);
        data_t a;
        data_t b;
        data_t res;
        // regfile takes a broadcast on the next edge
        while (pending[next_tag] || tag_on_bus(next_tag)) @(negedge clk);
        while (stall[unit]) @(negedge clk);
        dest = next_tag;
        next_tag = (next_tag == tag_t'(NUM_PREGS - 1)) ? tag_t'(1) : next_tag + tag_t'(1);
        a = exp_val[src1];
        b = use_imm ? imm : exp_val[src2];
        case (unit)
            UNIT_ALU: res = alu_model(alu_fn_e'(fn), a, b);
            UNIT_MUL: res = mul_model(fn[1:0], a, b);
            default:  res = div_model(fn[1:0], a, b);
        endcase
        exp_val[dest] = res;
        pending[dest] = 1'b1;
        dispatch = '{unit: unit, fn: fn, src1: src1, src2: src2, dest: dest,
                     use_imm: use_imm, imm: imm};
        dispatch_valid = 1'b1;
        dispatched++;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic load_const(input data_t v, output tag_t t);
        send_op(UNIT_ALU, 4'(ALU_ADD), '0, '0, 1'b1, v, t);
    endtask

    task automatic wait_idle(input int max_cycles);
        int n;
        n = 0;
        while (pending != '0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic check_bus(input string name, input wb_t bus);
        if (bus.valid) begin
            assert (pending[bus.tag])
                else report_failure($sformatf("%s broadcast tag 0x%h with no result outstanding",
                                              name, bus.tag));
            assert (bus.data == exp_val[bus.tag])
                else report_failure($sformatf("mismatch %s.data tag 0x%h expected 0x%h got 0x%h",
                                              name, bus.tag, exp_val[bus.tag], bus.data));
            pending[bus.tag] = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_bus("alu_wb", alu_wb);
            check_bus("mul_wb", mul_wb);
            check_bus("div_wb", div_wb);
            assert (exec_core_inst.exec_core_sva_inst.fail_count == 0)
                else report_failure("a protocol assertion on the DUT failed");
        end
    end

    // limit grows with every dispatch
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < dispatched * 40 + 2000) begin
            @(posedge clk);
            cycles++;
        end
        report_failure("watchdog timeout, results stopped arriving");
    end

    initial begin : stimulus
        tag_t c1;
        tag_t c2;
        tag_t x;
        tag_t y;
        tag_t d;
        tag_t t;
        data_t corner [5];
        dispatch_valid = 1'b0;
        dispatch = '0;
        rng = 32'h98f5_9be5;
        next_tag = tag_t'(1);
        dispatched = 0;
        pending = '0;
        for (int i = 0; i < NUM_PREGS; i++) begin
            exp_val[i] = '0;
        end
        corner = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0000, 32'h0000_0007};
        wait (rst_n === 1'b1);
        repeat (4) @(negedge clk);  // idle bus window after reset

        // every alu function, negative and positive operands
        load_const(32'hffff_fff3, c1);
        load_const(32'h0000_0005, c2);
        for (int f = 0; f < 10; f++) begin
            send_op(UNIT_ALU, 4'(f), c1, '0, 1'b1, next_random(), t);
            send_op(UNIT_ALU, 4'(f), c1, c2, 1'b0, '0, t);
            send_op(UNIT_ALU, 4'(f), c2, c1, 1'b0, '0, t);
        end

        // dependent chain, sources still in flight
        load_const(next_random(), x);
        send_op(UNIT_MUL, 4'(MD_MUL), x, x, 1'b0, '0, y);
        send_op(UNIT_DIV, 4'(MD_DIV), y, x, 1'b0, '0, d);
        send_op(UNIT_ALU, 4'(ALU_SUB), d, y, 1'b0, '0, t);
        send_op(UNIT_MUL, 4'(MD_MULH), t, x, 1'b0, '0, y);
        send_op(UNIT_DIV, 4'(MD_REMU), y, t, 1'b0, '0, d);
        send_op(UNIT_ALU, 4'(ALU_XOR), d, x, 1'b0, '0, t);

        for (int i = 0; i < 8; i++) begin
            load_const(next_random(), x);
            load_const(next_random(), y);
            for (int f = 0; f < 3; f++) begin
                send_op(UNIT_MUL, 4'(f), x, y, 1'b0, '0, t);
            end
            for (int f = 0; f < 4; f++) begin
                send_op(UNIT_DIV, 4'(f), x, y, 1'b0, '0, t);
            end
        end

        // sign edges, zero divisor, min / -1
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                load_const(corner[i], x);
                load_const(corner[j], y);
                for (int f = 0; f < 3; f++) begin
                    send_op(UNIT_MUL, 4'(f), x, y, 1'b0, '0, t);
                end
                for (int f = 0; f < 4; f++) begin
                    send_op(UNIT_DIV, 4'(f), x, y, 1'b0, '0, t);
                end
            end
        end

        // four multiplies held behind a divide fill the station
        wait_idle(2000);
        load_const(next_random(), x);
        load_const(next_random() | 32'h1, y);
        send_op(UNIT_DIV, 4'(MD_DIVU), x, y, 1'b0, '0, d);
        for (int i = 0; i < 4; i++) begin
            send_op(UNIT_MUL, 4'(i % 3), d, x, 1'b0, '0, t);
        end
        assert (stall[UNIT_MUL])
            else report_failure("multiplier stall stayed low with four waiting operations");
        for (int i = 0; i < 2; i++) begin
            send_op(UNIT_MUL, 4'(MD_MULHU), d, y, 1'b0, '0, t);
        end

        wait_idle(2000);
        if (pending != '0) begin
            report_failure($sformatf("%0d dispatched results never arrived",
                                     $countones(pending)));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
src/exec_pkg.sv
src/phys_regfile.sv
src/reservation_station.sv
src/int_alu.sv
src/seq_multiplier.sv
src/seq_divider.sv
src/exec_core.sv
verif/tb_clock.sv
verif/exec_core_sva.sv
verif/exec_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module exec_core_tb -o exec_core_sim

# the log decides, not the exit status of the simulator
./obj_dir/exec_core_sim 2>&1 | tee sim.log

grep -qx 'TEST RESULT: PASS' sim.log
echo "simulation passed"
